// File: include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// kseg0/kseg1 mapping on the data bus
// set to 0 to send virtual addresses straight to the bus
`define MIPS_DO_ADDR_TRANSLATION 1

// retired-write buffer between the pipeline and the debug trace
// must be a power of two, at least 2
`define MIPS_RETIRE_DEPTH 8

// two slots retire per cycle, so the queue needs this much room
// before it takes another pair
`define MIPS_RETIRE_SLOTS 2

`endif

// File: logic/mips_pkg.sv
package mips_pkg;

    // bus word, also used for pc
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] creg_addr_t;

    // debug trace byte write enable
    typedef logic [3:0] rwen_t;

    // bus access size
    // 0 byte, 1 half, 2 word
    typedef logic [1:0] size_t;

    // per-channel bus handshake
    //   idle        nothing outstanding
    //   addr_phase  req high, waiting for addr_ok
    //   data_phase  address taken, waiting for data_ok
    //   resp_hold   response held for the core
    typedef enum logic [1:0] {
        idle,
        addr_phase,
        data_phase,
        resp_hold
    } hs_state_t;

endpackage

// File: logic/addr_translate.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

// fixed mips segment mapping for data addresses
// kseg0 (0x8/0x9) and kseg1 (0xa/0xb) both fold onto the low 512MB
module addr_translate #(
    parameter bit do_translation = `MIPS_DO_ADDR_TRANSLATION
) (
    input  mips_pkg::word_t vaddr,
    output mips_pkg::word_t paddr
);

    logic [3:0] seg_in;
    logic [3:0] seg_out;

    assign seg_in = vaddr[31:28];

    always_comb begin
        seg_out = seg_in;
        if (do_translation) begin
            case (seg_in)
                // kseg0
                4'h8: seg_out = 4'h0;
                4'h9: seg_out = 4'h1;
                // kseg1, uncached alias of the same range
                4'ha: seg_out = 4'h0;
                4'hb: seg_out = 4'h1;
                // useg and kseg2/3 stay as they are
                default: seg_out = seg_in;
            endcase
        end
    end

    assign paddr = {seg_out, vaddr[27:0]};

endmodule

// File: logic/sram_handshake.sv
`timescale 1ns/1ps

// one sram-like bus channel
// at most one request in flight; response held until the core takes it
module sram_handshake (
    input  logic            clk,
    input  logic            rst,

    // core request side
    input  logic            core_valid,
    output logic            core_ready,

    // core response side
    output logic            resp_valid,
    input  logic            resp_ready,
    output mips_pkg::word_t resp_rdata,

    // bus side
    output logic            req,
    input  logic            addr_ok,
    input  logic            data_ok,
    input  mips_pkg::word_t rdata
);

    import mips_pkg::*;

    hs_state_t state;
    hs_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (core_valid) begin
                    state_next = addr_phase;
                end
            end
            addr_phase: begin
                if (addr_ok) begin
                    state_next = data_phase;
                end
            end
            data_phase: begin
                if (data_ok) begin
                    state_next = resp_hold;
                end
            end
            resp_hold: begin
                // a request already waiting goes straight to the bus
                if (resp_ready) begin
                    state_next = core_valid ? addr_phase : idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // read data captured once, then held for the whole response
    always_ff @(posedge clk) begin
        if (state == data_phase && data_ok) begin
            resp_rdata <= rdata;
        end
    end

    assign req        = (state == addr_phase);
    // the core's transfer is the bus address handshake
    assign core_ready = req && addr_ok;
    assign resp_valid = (state == resp_hold);

    // bus must not answer before it has taken the address
    a_data_ok_in_phase: assert property (
        @(posedge clk) disable iff (rst)
        data_ok |-> state == data_phase
    ) else $error("sram_handshake: data_ok outside data phase");

endmodule

// File: logic/retire_queue.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

// takes up to two retired writes per cycle, shows one per cycle on the
// debug trace; slot 0 is the older of a pair
module retire_queue #(
    parameter int depth = `MIPS_RETIRE_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [1:0]           retire_valid,
    output logic                 retire_ready,
    input  mips_pkg::word_t      retire_pc0,
    input  mips_pkg::word_t      retire_pc1,
    input  mips_pkg::creg_addr_t retire_wnum0,
    input  mips_pkg::creg_addr_t retire_wnum1,
    input  mips_pkg::word_t      retire_wdata0,
    input  mips_pkg::word_t      retire_wdata1,

    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    import mips_pkg::*;

    localparam int ptr_w = $clog2(depth);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [ptr_w:0]   cnt_t;

    word_t      pc_mem    [depth];
    creg_addr_t wnum_mem  [depth];
    word_t      wdata_mem [depth];

    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;

    logic [1:0] do_push;
    logic [1:0] n_push;
    logic       pop;
    word_t      head_pc;
    creg_addr_t head_wnum;
    word_t      head_wdata;

    // room for a full pair
    assign retire_ready = (count <= cnt_t'(depth - `MIPS_RETIRE_SLOTS));

    assign do_push = retire_ready ? retire_valid : 2'b00;
    assign n_push  = {1'b0, do_push[0]} + {1'b0, do_push[1]};

    // empty queue: slot 0 goes out the same cycle it arrives
    assign head_pc    = (count == '0) ? retire_pc0    : pc_mem[rd_ptr];
    assign head_wnum  = (count == '0) ? retire_wnum0  : wnum_mem[rd_ptr];
    assign head_wdata = (count == '0) ? retire_wdata0 : wdata_mem[rd_ptr];

    assign pop = (count != '0) || do_push[0];

    // slot 0 is always written too; if bypassed, rd_ptr steps past it
    always_ff @(posedge clk) begin
        if (do_push[0]) begin
            pc_mem[wr_ptr]    <= retire_pc0;
            wnum_mem[wr_ptr]  <= retire_wnum0;
            wdata_mem[wr_ptr] <= retire_wdata0;
        end
        if (do_push[1]) begin
            pc_mem[wr_ptr + ptr_t'(1)]    <= retire_pc1;
            wnum_mem[wr_ptr + ptr_t'(1)]  <= retire_wnum1;
            wdata_mem[wr_ptr + ptr_t'(1)] <= retire_wdata1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_t'(n_push);
            rd_ptr <= rd_ptr + ptr_t'(pop);
            count  <= count + cnt_t'(n_push) - cnt_t'(pop);
        end
    end

    // trace registers; wen off for idle cycles and for r0
    always_ff @(posedge clk) begin
        if (rst) begin
            debug_wb_rf_wen <= '0;
        end else begin
            debug_wb_rf_wen <= (pop && head_wnum != '0) ? '1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            debug_wb_pc       <= head_pc;
            debug_wb_rf_wnum  <= head_wnum;
            debug_wb_rf_wdata <= head_wdata;
        end
    end

    // a younger slot never retires without the older one
    a_no_slot1_alone: assert property (
        @(posedge clk) disable iff (rst)
        retire_valid != 2'b10
    ) else $error("retire_queue: illegal retire pattern 10");

    a_push_when_ready: assert property (
        @(posedge clk) disable iff (rst)
        (|retire_valid) |-> retire_ready
    ) else $error("retire_queue: retire while queue not ready");

endmodule

// File: logic/cpu_bus_top.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

// memory bus and retire trace shell
// channel 0 is instruction fetch, channel 1 is data
module cpu_bus_top #(
    parameter bit do_translation = `MIPS_DO_ADDR_TRANSLATION,
    parameter int retire_depth   = `MIPS_RETIRE_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,

    // fetch from the core
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    input  mips_pkg::word_t      fetch_addr,
    output logic                 fetch_resp_valid,
    input  logic                 fetch_resp_ready,
    output mips_pkg::word_t      fetch_rdata,

    // loads and stores from the core
    input  logic                 mem_valid,
    output logic                 mem_ready,
    input  logic                 mem_wr,
    input  mips_pkg::size_t      mem_size,
    input  mips_pkg::word_t      mem_addr,
    input  mips_pkg::word_t      mem_wdata,
    output logic                 mem_resp_valid,
    input  logic                 mem_resp_ready,
    output mips_pkg::word_t      mem_rdata,

    // instruction sram bus
    output logic                 inst_req,
    output logic                 inst_wr,
    output mips_pkg::size_t      inst_size,
    output mips_pkg::word_t      inst_addr,
    output mips_pkg::word_t      inst_wdata,
    input  mips_pkg::word_t      inst_rdata,
    input  logic                 inst_addr_ok,
    input  logic                 inst_data_ok,

    // data sram bus
    output logic                 data_req,
    output logic                 data_wr,
    output mips_pkg::size_t      data_size,
    output mips_pkg::word_t      data_addr,
    output mips_pkg::word_t      data_wdata,
    input  mips_pkg::word_t      data_rdata,
    input  logic                 data_addr_ok,
    input  logic                 data_data_ok,

    // retired register writes
    input  logic [1:0]           retire_valid,
    output logic                 retire_ready,
    input  mips_pkg::word_t      retire_pc0,
    input  mips_pkg::word_t      retire_pc1,
    input  mips_pkg::creg_addr_t retire_wnum0,
    input  mips_pkg::creg_addr_t retire_wnum1,
    input  mips_pkg::word_t      retire_wdata0,
    input  mips_pkg::word_t      retire_wdata1,

    // debug trace
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    import mips_pkg::*;

    logic [1:0] ch_valid;
    logic [1:0] ch_ready;
    logic [1:0] ch_resp_valid;
    logic [1:0] ch_resp_ready;
    logic [1:0] ch_req;
    logic [1:0] ch_addr_ok;
    logic [1:0] ch_data_ok;
    word_t      ch_rdata      [2];
    word_t      ch_resp_rdata [2];

    assign ch_valid      = {mem_valid, fetch_valid};
    assign ch_resp_ready = {mem_resp_ready, fetch_resp_ready};
    assign ch_addr_ok    = {data_addr_ok, inst_addr_ok};
    assign ch_data_ok    = {data_data_ok, inst_data_ok};
    assign ch_rdata[0]   = inst_rdata;
    assign ch_rdata[1]   = data_rdata;

    for (genvar g = 0; g < 2; g++) begin : g_chan
        sram_handshake sram_handshake_i (
            .clk        (clk),
            .rst        (rst),
            .core_valid (ch_valid[g]),
            .core_ready (ch_ready[g]),
            .resp_valid (ch_resp_valid[g]),
            .resp_ready (ch_resp_ready[g]),
            .resp_rdata (ch_resp_rdata[g]),
            .req        (ch_req[g]),
            .addr_ok    (ch_addr_ok[g]),
            .data_ok    (ch_data_ok[g]),
            .rdata      (ch_rdata[g])
        );
    end

    assign fetch_ready      = ch_ready[0];
    assign fetch_resp_valid = ch_resp_valid[0];
    assign fetch_rdata      = ch_resp_rdata[0];
    assign mem_ready        = ch_ready[1];
    assign mem_resp_valid   = ch_resp_valid[1];
    assign mem_rdata        = ch_resp_rdata[1];

    // fetches are always full-word reads
    assign inst_req   = ch_req[0];
    assign inst_wr    = 1'b0;
    assign inst_size  = size_t'(2);
    assign inst_addr  = fetch_addr;
    assign inst_wdata = '0;

    assign data_req   = ch_req[1];
    assign data_wr    = mem_wr;
    assign data_size  = mem_size;
    assign data_wdata = mem_wdata;

    // only data addresses are mapped
    addr_translate #(
        .do_translation (do_translation)
    ) addr_translate_i (
        .vaddr (mem_addr),
        .paddr (data_addr)
    );

    retire_queue #(
        .depth (retire_depth)
    ) retire_queue_i (
        .clk               (clk),
        .rst               (rst),
        .retire_valid      (retire_valid),
        .retire_ready      (retire_ready),
        .retire_pc0        (retire_pc0),
        .retire_pc1        (retire_pc1),
        .retire_wnum0      (retire_wnum0),
        .retire_wnum1      (retire_wnum1),
        .retire_wdata0     (retire_wdata0),
        .retire_wdata1     (retire_wdata1),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

// free-running clock, starts low
module tb_clock #(
    parameter int period_ns = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

// File: verif/cpu_bus_tb.sv
`timescale 1ns/1ps

module cpu_bus_tb;

    import mips_pkg::*;

    localparam int wait_limit = 40;
    localparam int n_rows     = 16;

    typedef enum logic [1:0] {
        k_fetch,
        k_load,
        k_store,
        k_retire
    } kind_t;

    typedef struct packed {
        kind_t      kind;
        logic       with_next;
        word_t      addr;
        size_t      size;
        word_t      data;
        word_t      exp_addr;
        word_t      exp_rdata;
        logic [1:0] rv;
        word_t      pc0;
        creg_addr_t wnum0;
        word_t      wdata0;
        word_t      pc1;
        creg_addr_t wnum1;
        word_t      wdata1;
    } row_t;

    typedef struct packed {
        word_t      pc;
        creg_addr_t wnum;
        word_t      wdata;
    } trace_ent_t;

    logic       clk;
    logic       rst;
    logic       fetch_valid;
    logic       fetch_ready;
    word_t      fetch_addr;
    logic       fetch_resp_valid;
    logic       fetch_resp_ready;
    word_t      fetch_rdata;
    logic       mem_valid;
    logic       mem_ready;
    logic       mem_wr;
    size_t      mem_size;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_resp_valid;
    logic       mem_resp_ready;
    word_t      mem_rdata;
    logic       inst_req;
    logic       inst_wr;
    size_t      inst_size;
    word_t      inst_addr;
    word_t      inst_wdata;
    word_t      inst_rdata;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    logic       data_req;
    logic       data_wr;
    size_t      data_size;
    word_t      data_addr;
    word_t      data_wdata;
    word_t      data_rdata;
    logic       data_addr_ok;
    logic       data_data_ok;
    logic [1:0] retire_valid;
    logic       retire_ready;
    word_t      retire_pc0;
    word_t      retire_pc1;
    creg_addr_t retire_wnum0;
    creg_addr_t retire_wnum1;
    word_t      retire_wdata0;
    word_t      retire_wdata1;
    word_t      debug_wb_pc;
    rwen_t      debug_wb_rf_wen;
    creg_addr_t debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    // channel 0 is the instruction bus, channel 1 the data bus
    logic [1:0] req_v;
    logic [1:0] ready_v;
    logic [1:0] rvalid_v;
    logic [1:0] wr_v;
    word_t      addr_v  [2];
    word_t      wdata_v [2];
    word_t      rdata_v [2];
    size_t      size_v  [2];

    row_t       rows [n_rows];
    word_t      mem_model [word_t];
    trace_ent_t trace_q [$];
    trace_ent_t trace_shown;
    logic       trace_pending;
    int         checks;
    int         errors;
    int         timeouts;

    assign req_v      = {data_req, inst_req};
    assign ready_v    = {mem_ready, fetch_ready};
    assign rvalid_v   = {mem_resp_valid, fetch_resp_valid};
    assign wr_v       = {data_wr, inst_wr};
    assign addr_v[0]  = inst_addr;
    assign addr_v[1]  = data_addr;
    assign wdata_v[0] = inst_wdata;
    assign wdata_v[1] = data_wdata;
    assign rdata_v[0] = fetch_rdata;
    assign rdata_v[1] = mem_rdata;
    assign size_v[0]  = inst_size;
    assign size_v[1]  = data_size;

    tb_clock #(.period_ns(4)) tb_clock_i (.clk(clk));

    cpu_bus_top cpu_bus_top_i (.*);

    // untouched memory words, mixed from every address bit
    function automatic word_t fill_word(input word_t a);
        return {a[7:0], a[31:24], a[15:8], a[23:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic word_t mem_read(input word_t a);
        if (mem_model.exists(a >> 2)) begin
            return mem_model[a >> 2];
        end
        return fill_word(a);
    endfunction

    function automatic row_t access_row(input kind_t kind, input word_t addr, input word_t data,
                                        input word_t exp_addr, input word_t exp_rdata);
        row_t r;
        r           = '0;
        r.kind      = kind;
        r.addr      = addr;
        r.size      = size_t'(2);
        r.data      = data;
        r.exp_addr  = exp_addr;
        r.exp_rdata = exp_rdata;
        return r;
    endfunction

    function automatic row_t retire_row(input logic [1:0] rv, input word_t pc0,
                                        input creg_addr_t wnum0, input word_t wdata0,
                                        input word_t pc1, input creg_addr_t wnum1,
                                        input word_t wdata1);
        row_t r;
        r        = '0;
        r.kind   = k_retire;
        r.rv     = rv;
        r.pc0    = pc0;
        r.wnum0  = wnum0;
        r.wdata0 = wdata0;
        r.pc1    = pc1;
        r.wnum1  = wnum1;
        r.wdata1 = wdata1;
        return r;
    endfunction

    function automatic void build_table();
        // fetches are never translated
        rows[0]  = access_row(k_fetch, 32'h8000_1000, '0, 32'h8000_1000, fill_word(32'h8000_1000));
        rows[1]  = access_row(k_fetch, 32'hbfc0_0004, '0, 32'hbfc0_0004, fill_word(32'hbfc0_0004));
        // kseg0 and kseg1 fold onto the low 512MB, useg passes
        rows[2]  = access_row(k_load, 32'h8000_0100, '0, 32'h0000_0100, fill_word(32'h0000_0100));
        rows[3]  = access_row(k_load, 32'h9000_0200, '0, 32'h1000_0200, fill_word(32'h1000_0200));
        rows[4]  = access_row(k_load, 32'ha000_0300, '0, 32'h0000_0300, fill_word(32'h0000_0300));
        rows[5]  = access_row(k_load, 32'hb000_0400, '0, 32'h1000_0400, fill_word(32'h1000_0400));
        rows[6]  = access_row(k_load, 32'h0040_0500, '0, 32'h0040_0500, fill_word(32'h0040_0500));
        // byte load, the bus still returns the whole word
        rows[6].size = size_t'(0);
        rows[7]  = access_row(k_store, 32'h8000_0600, 32'hcafe_f00d, 32'h0000_0600, '0);
        rows[8]  = access_row(k_load, 32'h8000_0600, '0, 32'h0000_0600, 32'hcafe_f00d);
        // uncached alias of the same word
        rows[9]  = access_row(k_load, 32'ha000_0600, '0, 32'h0000_0600, 32'hcafe_f00d);
        rows[10] = access_row(k_fetch, 32'h8000_2000, '0, 32'h8000_2000, fill_word(32'h8000_2000));
        rows[10].with_next = 1'b1;
        rows[11] = access_row(k_load, 32'h9000_0800, '0, 32'h1000_0800, fill_word(32'h1000_0800));
        rows[12] = retire_row(2'b11, 32'hbfc0_0100, 5'd3, 32'h0000_0011,
                              32'hbfc0_0104, 5'd7, 32'h0000_0022);
        rows[13] = retire_row(2'b01, 32'hbfc0_0108, 5'd31, 32'h0000_0033, '0, '0, '0);
        rows[14] = retire_row(2'b01, 32'hbfc0_010c, 5'd0, 32'h0000_0044, '0, '0, '0);
        rows[15] = retire_row(2'b11, 32'hbfc0_0110, 5'd5, 32'h0000_0055,
                              32'hbfc0_0114, 5'd0, 32'h0000_0066);
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            flag_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            flag_mismatch($sformatf("%s bus address %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_rdata(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            flag_mismatch($sformatf("%s read data %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_ctrl(input logic wr, input size_t size, input word_t wdata,
                              input logic exp_wr, input size_t exp_size, input word_t exp_wdata,
                              input string what);
        checks++;
        if (wr !== exp_wr || size !== exp_size || wdata !== exp_wdata) begin
            flag_mismatch($sformatf("%s wr %b size %0d wdata %h, expected %b %0d %h",
                                    what, wr, size, wdata, exp_wr, exp_size, exp_wdata));
        end
    endtask

    task automatic check_trace(input word_t pc, input creg_addr_t wnum, input word_t wdata,
                               input rwen_t wen, input trace_ent_t exp);
        rwen_t exp_wen;
        // r0 writes show their pc with the enables off
        exp_wen = (exp.wnum != '0) ? 4'hf : 4'h0;
        checks++;
        if (pc !== exp.pc || wnum !== exp.wnum || wdata !== exp.wdata || wen !== exp_wen) begin
            flag_mismatch($sformatf("trace pc %h r%0d %h wen %b, expected pc %h r%0d %h wen %b",
                                    pc, wnum, wdata, wen, exp.pc, exp.wnum, exp.wdata, exp_wen));
        end
    endtask

    task automatic drive_bus(input bit ch, input logic aok, input logic dok, input word_t d);
        if (ch == 1'b0) begin
            inst_addr_ok = aok;
            inst_data_ok = dok;
            inst_rdata   = d;
        end else begin
            data_addr_ok = aok;
            data_data_ok = dok;
            data_rdata   = d;
        end
    endtask

    // sram slave: random address and data latency, one request at a time
    task automatic serve_bus(input bit ch);
        int    delay;
        word_t a;
        logic  w;
        word_t wd;
        drive_bus(ch, 1'b0, 1'b0, '0);
        forever begin
            @(negedge clk);
            if (req_v[ch]) begin
                delay = $urandom_range(0, 3);
                repeat (delay) @(negedge clk);
                a  = addr_v[ch];
                w  = wr_v[ch];
                wd = wdata_v[ch];
                drive_bus(ch, 1'b1, 1'b0, '0);
                @(negedge clk);
                drive_bus(ch, 1'b0, 1'b0, '0);
                delay = $urandom_range(0, 3);
                repeat (delay) @(negedge clk);
                if (w) begin
                    mem_model[a >> 2] = wd;
                end
                drive_bus(ch, 1'b0, 1'b1, w ? '0 : mem_read(a));
                @(negedge clk);
                drive_bus(ch, 1'b0, 1'b0, '0);
            end
        end
    endtask

    task automatic set_core(input bit ch, input logic valid, input logic ready, input row_t r);
        if (ch == 1'b0) begin
            fetch_valid      = valid;
            fetch_addr       = r.addr;
            fetch_resp_ready = ready;
        end else begin
            mem_valid      = valid;
            mem_wr         = (r.kind == k_store);
            mem_size       = r.size;
            mem_addr       = r.addr;
            mem_wdata      = r.data;
            mem_resp_ready = ready;
        end
    endtask

    task automatic issue_access(input bit ch, input row_t r);
        int    n;
        int    hold;
        logic  got;
        word_t held;
        string what;
        what = (ch == 1'b0) ? "fetch" : "data";
        @(negedge clk);
        set_core(ch, 1'b1, 1'b0, r);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            got = ready_v[ch];
            // req must hold from the cycle after valid until addr_ok
            if (!got && n > 1 && !req_v[ch]) begin
                flag_mismatch($sformatf("%s req dropped before addr_ok", what));
            end
        end while (!got && n < wait_limit);
        if (!got) begin
            note_timeout($sformatf("%s request was never accepted", what));
            return;
        end
        check_addr(addr_v[ch], r.exp_addr, what);
        check_ctrl(wr_v[ch], size_v[ch], wdata_v[ch], r.kind == k_store,
                   (ch == 1'b0) ? size_t'(2) : r.size, (ch == 1'b0) ? '0 : r.data, what);
        @(negedge clk);
        set_core(ch, 1'b0, 1'b0, r);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            got = rvalid_v[ch];
        end while (!got && n < wait_limit);
        if (!got) begin
            note_timeout($sformatf("%s response never arrived", what));
            return;
        end
        // hold off resp_ready and watch the response stay put
        held = rdata_v[ch];
        hold = $urandom_range(0, 3);
        repeat (hold) begin
            @(posedge clk);
            if (!rvalid_v[ch] || rdata_v[ch] !== held) begin
                flag_mismatch($sformatf("%s response not held before resp_ready", what));
            end
        end
        @(negedge clk);
        set_core(ch, 1'b0, 1'b1, r);
        @(posedge clk);
        if (r.kind != k_store) begin
            check_rdata(rdata_v[ch], r.exp_rdata, what);
        end
        @(negedge clk);
        set_core(ch, 1'b0, 1'b0, r);
    endtask

    task automatic send_retire(input row_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (!retire_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!retire_ready) begin
            note_timeout("retire queue never had room");
            return;
        end
        retire_valid  = r.rv;
        retire_pc0    = r.pc0;
        retire_wnum0  = r.wnum0;
        retire_wdata0 = r.wdata0;
        retire_pc1    = r.pc1;
        retire_wnum1  = r.wnum1;
        retire_wdata1 = r.wdata1;
        @(negedge clk);
        retire_valid = 2'b00;
    endtask

    task automatic run_row(input row_t r);
        case (r.kind)
            k_fetch:  issue_access(1'b0, r);
            k_retire: send_retire(r);
            default:  issue_access(1'b1, r);
        endcase
    endtask

    initial serve_bus(1'b0);
    initial serve_bus(1'b1);

    // reference model of the trace: one entry out per cycle, in retire order
    initial begin : trace_monitor
        trace_ent_t ent;
        trace_pending = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                trace_q.delete();
                trace_pending = 1'b0;
            end else begin
                if (trace_pending) begin
                    check_trace(debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                                debug_wb_rf_wen, trace_shown);
                end else begin
                    check_level(|debug_wb_rf_wen, 1'b0, "idle trace wen");
                end
                // retires are only driven once the queue has shown room
                if (retire_valid[0]) begin
                    ent = '{pc: retire_pc0, wnum: retire_wnum0, wdata: retire_wdata0};
                    trace_q.push_back(ent);
                end
                if (retire_valid[1]) begin
                    ent = '{pc: retire_pc1, wnum: retire_wnum1, wdata: retire_wdata1};
                    trace_q.push_back(ent);
                end
                trace_pending = (trace_q.size() != 0);
                if (trace_pending) begin
                    trace_shown = trace_q.pop_front();
                end
            end
        end
    end

    initial begin : main
        int i;
        int n;
        checks           = 0;
        errors           = 0;
        timeouts         = 0;
        rst              = 1'b1;
        fetch_valid      = 1'b0;
        fetch_addr       = '0;
        fetch_resp_ready = 1'b0;
        mem_valid        = 1'b0;
        mem_wr           = 1'b0;
        mem_size         = '0;
        mem_addr         = '0;
        mem_wdata        = '0;
        mem_resp_ready   = 1'b0;
        retire_valid     = 2'b00;
        retire_pc0       = '0;
        retire_pc1       = '0;
        retire_wnum0     = '0;
        retire_wnum1     = '0;
        retire_wdata0    = '0;
        retire_wdata1    = '0;
        void'($urandom(83));
        build_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_level(inst_req, 1'b0, "inst_req after reset");
        check_level(data_req, 1'b0, "data_req after reset");
        check_level(fetch_ready, 1'b0, "fetch_ready after reset");
        check_level(mem_ready, 1'b0, "mem_ready after reset");
        check_level(|debug_wb_rf_wen, 1'b0, "trace wen after reset");
        check_level(retire_ready, 1'b1, "retire_ready after reset");
        i = 0;
        while (i < n_rows && timeouts == 0) begin
            if (rows[i].with_next && i + 1 < n_rows) begin
                // fetch and load in flight at the same time
                fork
                    run_row(rows[i]);
                    run_row(rows[i + 1]);
                join
                i += 2;
            end else begin
                run_row(rows[i]);
                i += 1;
            end
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((trace_q.size() != 0 || trace_pending) && n < wait_limit);
        if (trace_q.size() != 0 || trace_pending) begin
            note_timeout("trace did not drain");
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
logic/mips_pkg.sv
logic/addr_translate.sv
logic/sram_handshake.sv
logic/retire_queue.sv
logic/cpu_bus_top.sv
verif/tb_clock.sv
verif/cpu_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_bus testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_bus_tb -f vlog.f -o cpu_bus_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpu_bus_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$log"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
